//--- dv/mem_pipe_tests.svh
task automatic test_reset_state();
   check_flag("issue_ready", issue_ready, 1'b1);
   check_flag("retire_valid", retire_valid, 1'b0);
   for (int i = 0; i < `CORE_NUM_REGS; i++) begin
      check_dbg(reg_id_t'(i));
   end
endtask

task automatic test_store_load();
   logic [31:0] a;
   logic [31:0] patch;
   a     = next_rand();
   patch = next_rand();
   issue_mem_uop(op_store, size_dword, 3'd0, a, 64'h0, 32'h40, 32'h8);
   issue_mem_uop(op_load_gpr, size_dword, 3'd1, 32'h0, 64'h0, 32'h40, 32'h8);
   end_issue();
   wait_retired();
   check_dbg(3'd1);
   check_gpr("dword load after dword store", dbg_gpr, a);
   // Byte 2 of the same dword gets replaced.
   issue_mem_uop(op_store, size_byte, 3'd0, patch, 64'h0, 32'h40, 32'ha);
   issue_mem_uop(op_load_gpr, size_dword, 3'd2, 32'h0, 64'h0, 32'h40, 32'h8);
   end_issue();
   wait_retired();
   check_dbg(3'd2);
   check_gpr("dword load after byte store", dbg_gpr, {a[31:24], patch[7:0], a[15:0]});
endtask

task automatic test_qword_mm();
   logic [63:0] q;
   q[63:32] = next_rand();
   q[31:0]  = next_rand();
   issue_mem_uop(op_store, size_qword, 3'd0, 32'h0, q, 32'h100, 32'h0);
   issue_mem_uop(op_load_mm, size_qword, 3'd3, 32'h0, 64'h0, 32'h100, 32'h0);
   issue_mem_uop(op_load_gpr, size_word, 3'd4, 32'h0, 64'h0, 32'hf8, 32'h8); // Same word.
   end_issue();
   wait_retired();
   check_dbg(3'd3);
   check_mm("qword load into MM register", dbg_mm, q);
   check_dbg(3'd4);
   check_gpr("word load of the qword", dbg_gpr, {16'h0, q[15:0]});
endtask

task automatic test_move_sp();
   logic [31:0] a;
   logic [31:0] a_low;
   logic [31:0] b;
   logic [31:0] sp;
   a     = next_rand();
   a_low = next_rand();
   b     = next_rand();
   sp    = next_rand();
   // B is random too, so a move that took B would show up.
   issue_reg_uop(op_move, size_dword, 3'd5, a, b, sp, 1'b0);
   issue_reg_uop(op_move, size_byte, 3'd5, a_low, b, sp, 1'b0);
   issue_reg_uop(op_sp_add, size_dword, 3'd0, a, b, sp, 1'b1);
   issue_reg_uop(op_sp_add, size_dword, 3'd0, a, b, sp, 1'b0);
   end_issue();
   wait_retired();
   check_dbg(3'd5);
   check_gpr("byte move over dword move", dbg_gpr, {a[31:8], a_low[7:0]});
endtask

task automatic test_back_to_back();
   int          start;
   logic [31:0] d;
   logic [31:0] m;
   logic [31:0] b;
   logic [31:0] sp;
   logic [63:0] q;
   start    = retired_count;
   d        = next_rand();
   m        = next_rand();
   b        = next_rand();
   sp       = next_rand();
   q[63:32] = next_rand();
   q[31:0]  = next_rand();
   issue_mem_uop(op_store, size_dword, 3'd0, d, 64'h0, 32'h200, 32'h0);
   issue_mem_uop(op_load_gpr, size_dword, 3'd6, 32'h0, 64'h0, 32'h1f0, 32'h10);
   issue_reg_uop(op_move, size_word, 3'd7, m, b, sp, 1'b0);
   issue_reg_uop(op_sp_add, size_dword, 3'd0, m, b, sp, 1'b1);
   issue_mem_uop(op_store, size_qword, 3'd0, 32'h0, q, 32'h208, 32'h0);
   issue_mem_uop(op_load_mm, size_qword, 3'd6, 32'h0, 64'h0, 32'h208, 32'h0);
   issue_reg_uop(op_nop, size_dword, 3'd0, 32'h0, 32'h0, sp, 1'b0);
   issue_mem_uop(op_load_gpr, size_byte, 3'd7, 32'h0, 64'h0, 32'h208, 32'h3);
   end_issue();
   wait_retired();
   repeat (5) @(negedge CLK);  // Room for a duplicate retire to show.
   if (retired_count - start != 8) begin
      errors++;
      $display("The back-to-back burst retired %0d micro-ops instead of 8",
               retired_count - start);
   end
   check_dbg(3'd6);
   check_dbg(3'd7);
endtask

//--- dv/mem_pipe_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module mem_pipe_tb
   import uop_pkg::*;
();

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 4;
   localparam int NUM_UOPS     = 19;                    // Micro-ops issued by all tests.
   localparam int RAM_BYTES    = `CORE_RAM_WORDS * 8;

   typedef struct packed {
      uop_kind_t               kind;
      op_size_t                size;
      reg_id_t                 drid;
      logic [`CORE_GPR_W-1:0]  a;
      logic [`CORE_GPR_W-1:0]  b;
      logic [`CORE_MM_W-1:0]   mm_a;
      logic [`CORE_GPR_W-1:0]  sp;
      logic [`CORE_ADDR_W-1:0] base;
      logic [`CORE_ADDR_W-1:0] disp;
      logic                    add_imm;
   } uop_t;

   // What one retire should show.
   typedef struct packed {
      uop_kind_t              kind;
      reg_id_t                drid;
      logic [`CORE_GPR_W-1:0] gpr;
      logic [`CORE_MM_W-1:0]  mm;
      logic [`CORE_GPR_W-1:0] sp;
      logic                   chk_gpr;
      logic                   chk_mm;
   } retire_t;

   logic                    CLK;
   logic                    reset;
   logic                    issue_valid;
   logic                    issue_ready;
   uop_kind_t               issue_kind;
   op_size_t                issue_size;
   reg_id_t                 issue_drid;
   logic [`CORE_GPR_W-1:0]  issue_a;
   logic [`CORE_GPR_W-1:0]  issue_b;
   logic [`CORE_MM_W-1:0]   issue_mm_a;
   logic [`CORE_GPR_W-1:0]  issue_sp;
   logic [`CORE_ADDR_W-1:0] issue_base;
   logic [`CORE_ADDR_W-1:0] issue_disp;
   logic                    issue_add_imm;
   logic                    retire_valid;
   uop_kind_t               retire_kind;
   reg_id_t                 retire_drid;
   logic [`CORE_GPR_W-1:0]  retire_gpr;
   logic [`CORE_MM_W-1:0]   retire_mm;
   logic [`CORE_GPR_W-1:0]  retire_sp;
   reg_id_t                 dbg_id;
   logic [`CORE_GPR_W-1:0]  dbg_gpr;
   logic [`CORE_MM_W-1:0]   dbg_mm;

   logic [`CORE_GPR_W-1:0]  gpr_model [`CORE_NUM_REGS];
   logic [`CORE_MM_W-1:0]   mm_model  [`CORE_NUM_REGS];
   logic [7:0]              ram_model [RAM_BYTES];
   retire_t                 exp_q [$];
   int                      errors        = 0;
   int                      issued_count  = 0;
   int                      retired_count = 0;
   logic [31:0]             lcg_state     = 32'hd913e125;

   mem_pipe_top u_mem_pipe_top (.*);

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic check_gpr(input string what, input logic [`CORE_GPR_W-1:0] got,
                            input logic [`CORE_GPR_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_mm(input string what, input logic [`CORE_MM_W-1:0] got,
                           input logic [`CORE_MM_W-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_kind(input string what, input uop_kind_t got, input uop_kind_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      end
   endtask

   task automatic check_reg(input string what, input reg_id_t got, input reg_id_t exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Applies one micro-op to the reference model, in issue order, and queues its retire.
   task automatic predict(input uop_t u);
      retire_t                r;
      int                     ea;
      int                     nb;
      logic [`CORE_GPR_W-1:0] mask;
      logic [`CORE_GPR_W-1:0] ld;
      logic [`CORE_MM_W-1:0]  word;
      ea   = int'((u.base + u.disp) & (RAM_BYTES - 1));
      nb   = 1 << u.size;
      mask = (nb >= 4) ? 32'hffff_ffff : 32'((64'd1 << (8 * nb)) - 64'd1);
      for (int i = 0; i < 8; i++) begin
         word[8*i +: 8] = ram_model[(ea & ~7) + i];
      end
      ld        = 32'(word >> (8 * (ea & 7))) & mask;
      r         = '0;
      r.kind    = u.kind;
      r.drid    = u.drid;
      r.sp      = u.add_imm ? u.sp + u.b : u.sp;
      case (u.kind)
         op_load_gpr: begin
            gpr_model[u.drid] = (gpr_model[u.drid] & ~mask) | (ld & mask);
            r.gpr     = gpr_model[u.drid];
            r.chk_gpr = 1'b1;
         end
         op_move: begin
            gpr_model[u.drid] = (gpr_model[u.drid] & ~mask) | (u.a & mask);
            r.gpr     = gpr_model[u.drid];
            r.chk_gpr = 1'b1;
         end
         op_load_mm: begin
            mm_model[u.drid] = word;
            r.mm     = word;
            r.chk_mm = 1'b1;
         end
         op_store: begin
            if (u.size == size_qword) begin
               for (int i = 0; i < 8; i++) ram_model[(ea & ~7) + i] = u.mm_a[8*i +: 8];
            end else begin
               for (int i = 0; i < nb; i++) ram_model[ea + i] = u.a[8*i +: 8];
            end
         end
         default: ;
      endcase
      exp_q.push_back(r);
   endtask

   task automatic compare_retire();
      retire_t e;
      if (exp_q.size() == 0) begin
         errors++;
         $display("A micro-op retired at %0t although none was outstanding", $time);
      end else begin
         e = exp_q.pop_front();
         retired_count++;
         check_kind("retire_kind", retire_kind, e.kind);
         check_reg("retire_drid", retire_drid, e.drid);
         check_gpr("retire_sp", retire_sp, e.sp);
         if (e.chk_gpr) check_gpr("retire_gpr", retire_gpr, e.gpr);
         if (e.chk_mm) check_mm("retire_mm", retire_mm, e.mm);
      end
   endtask

   // Holds issue_valid until the micro-op is accepted, so consecutive calls issue back to back.
   task automatic send_uop(input uop_t u);
      predict(u);
      issued_count++;
      @(posedge CLK);
      issue_valid   <= 1'b1;
      issue_kind    <= u.kind;
      issue_size    <= u.size;
      issue_drid    <= u.drid;
      issue_a       <= u.a;
      issue_b       <= u.b;
      issue_mm_a    <= u.mm_a;
      issue_sp      <= u.sp;
      issue_base    <= u.base;
      issue_disp    <= u.disp;
      issue_add_imm <= u.add_imm;
      do @(negedge CLK); while (!issue_ready);
   endtask

   task automatic issue_mem_uop(input uop_kind_t kind, input op_size_t size, input reg_id_t drid,
                                input logic [31:0] a, input logic [63:0] mm_a,
                                input logic [31:0] base, input logic [31:0] disp);
      send_uop('{kind, size, drid, a, 32'h0, mm_a, 32'h0, base, disp, 1'b0});
   endtask

   task automatic issue_reg_uop(input uop_kind_t kind, input op_size_t size, input reg_id_t drid,
                                input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] sp, input logic add_imm);
      send_uop('{kind, size, drid, a, b, 64'h0, sp, 32'h0, 32'h0, add_imm});
   endtask

   task automatic end_issue();
      @(posedge CLK);
      issue_valid <= 1'b0;
   endtask

   task automatic wait_retired();
      while (exp_q.size() != 0) @(negedge CLK);
   endtask

   task automatic check_dbg(input reg_id_t id);
      @(posedge CLK);
      dbg_id <= id;
      @(negedge CLK);
      check_gpr($sformatf("dbg_gpr[%0d]", id), dbg_gpr, gpr_model[id]);
      check_mm($sformatf("dbg_mm[%0d]", id), dbg_mm, mm_model[id]);
   endtask

   `include "mem_pipe_tests.svh"

   initial begin
      forever begin
         @(negedge CLK);
         if (!reset && retire_valid) compare_retire();
      end
   end

   initial begin
      #((NUM_UOPS * 10 + RESET_CYCLES) * CLK_PERIOD);
      $display("Timeout: the pipeline stopped retiring micro-ops");
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      CLK           = 1'b0;
      reset         = 1'b1;
      issue_valid   = 1'b0;
      issue_kind    = op_nop;
      issue_size    = size_byte;
      issue_drid    = '0;
      issue_a       = '0;
      issue_b       = '0;
      issue_mm_a    = '0;
      issue_sp      = '0;
      issue_base    = '0;
      issue_disp    = '0;
      issue_add_imm = 1'b0;
      dbg_id        = '0;
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
         gpr_model[i] = '0;
         mm_model[i]  = '0;
      end
      for (int i = 0; i < RAM_BYTES; i++) ram_model[i] = '0; // RAM is cleared by reset.
      repeat (RESET_CYCLES) @(posedge CLK);
      reset <= 1'b0;
      @(negedge CLK);
      test_reset_state();
      test_store_load();
      test_qword_mm();
      test_move_sp();
      test_back_to_back();
      repeat (5) @(negedge CLK);
      $display("Summary: %0d issued, %0d retired, %0d error(s)",
               issued_count, retired_count, errors);
      if (errors == 0 && exp_q.size() == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
+incdir+dv
logic/uop_pkg.sv
logic/wb_pkg.sv
logic/stage_latch.sv
logic/address_stage.sv
logic/memory_stage.sv
logic/writeback_stage.sv
logic/data_ram.sv
logic/mem_pipe_top.sv
dv/mem_pipe_tb.sv

//--- logic/address_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module address_stage
   import uop_pkg::*;
(
   input  wire logic                    CLK,
   input  wire logic                    reset,
   input  wire logic                    issue_valid,
   output logic                         issue_ready,
   input  wire uop_kind_t               issue_kind,
   input  wire op_size_t                issue_size,
   input  wire reg_id_t                 issue_drid,
   input  wire logic [`CORE_GPR_W-1:0]  issue_a,
   input  wire logic [`CORE_GPR_W-1:0]  issue_b,
   input  wire logic [`CORE_MM_W-1:0]   issue_mm_a,
   input  wire logic [`CORE_GPR_W-1:0]  issue_sp,
   input  wire logic [`CORE_ADDR_W-1:0] issue_base,
   input  wire logic [`CORE_ADDR_W-1:0] issue_disp,
   input  wire logic                    issue_add_imm,
   input  wire logic                    stall,
   output logic                         out_valid,
   output addr_payload_t                out_data
);

   addr_payload_t issue_data;

   always_comb begin
      issue_data.kind    = issue_kind;
      issue_data.size    = issue_size;
      issue_data.drid    = issue_drid;
      issue_data.a       = issue_a;
      issue_data.b       = issue_b;
      issue_data.mm_a    = issue_mm_a;
      issue_data.sp      = issue_sp;
      issue_data.addr    = issue_base + issue_disp; // Effective address.
      issue_data.add_imm = issue_add_imm;
   end

   stage_latch #(
      .payload_t(addr_payload_t)
   ) u_latch (
      .CLK      (CLK),
      .reset    (reset),
      .in_valid (issue_valid),
      .in_data  (issue_data),
      .stall    (stall),
      .out_valid(out_valid),
      .out_data (out_data),
      .ready    (issue_ready)
   );

endmodule

`default_nettype wire

//--- logic/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath widths.
`define CORE_ADDR_W    32
`define CORE_GPR_W     32
`define CORE_MM_W      64

// Data RAM depth in 64-bit words.
`define CORE_RAM_WORDS 256

// Entries in each register file.
`define CORE_NUM_REGS  8

`endif

//--- logic/data_ram.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module data_ram
   import wb_pkg::*;
(
   input  wire logic                    CLK,
   input  wire logic                    reset,
   input  wire logic                    wb_cyc,
   input  wire logic                    wb_stb,
   input  wire logic                    wb_we,
   input  wire logic [`CORE_ADDR_W-1:0] wb_adr,
   input  wire wb_sel_t                 wb_sel,
   input  wire logic [`CORE_MM_W-1:0]   wb_dat_w,
   output logic                         wb_ack,
   output logic [`CORE_MM_W-1:0]        wb_dat_r
);

   localparam int IDX_W = $clog2(`CORE_RAM_WORDS);

   logic [`CORE_MM_W-1:0] mem [`CORE_RAM_WORDS];
   logic [IDX_W-1:0]      idx;
   logic                  req;

   assign idx = wb_adr[3 +: IDX_W];           // Byte address to word index.
   assign req = wb_cyc && wb_stb && !wb_ack;  // One ack per request.

   always_ff @(posedge CLK) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= req;
      end
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < `CORE_RAM_WORDS; i++) mem[i] <= '0;
      end else if (req && wb_we) begin
         for (int b = 0; b < `CORE_MM_W/8; b++) begin
            if (wb_sel[b]) mem[idx][b*8 +: 8] <= wb_dat_w[b*8 +: 8];
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (req) wb_dat_r <= mem[idx];
   end

   a_ack_in_cycle: assert property (@(posedge CLK) disable iff (reset)
      wb_ack |-> wb_cyc);

endmodule

`default_nettype wire

//--- logic/mem_pipe_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module mem_pipe_top
   import uop_pkg::*;
   import wb_pkg::*;
(
   input  wire logic                    CLK,
   input  wire logic                    reset,
   input  wire logic                    issue_valid,
   output logic                         issue_ready,
   input  wire uop_kind_t               issue_kind,
   input  wire op_size_t                issue_size,
   input  wire reg_id_t                 issue_drid,
   input  wire logic [`CORE_GPR_W-1:0]  issue_a,
   input  wire logic [`CORE_GPR_W-1:0]  issue_b,
   input  wire logic [`CORE_MM_W-1:0]   issue_mm_a,
   input  wire logic [`CORE_GPR_W-1:0]  issue_sp,
   input  wire logic [`CORE_ADDR_W-1:0] issue_base,
   input  wire logic [`CORE_ADDR_W-1:0] issue_disp,
   input  wire logic                    issue_add_imm,
   output logic                         retire_valid,
   output uop_kind_t                    retire_kind,
   output reg_id_t                      retire_drid,
   output logic [`CORE_GPR_W-1:0]       retire_gpr,
   output logic [`CORE_MM_W-1:0]        retire_mm,
   output logic [`CORE_GPR_W-1:0]       retire_sp,
   input  wire reg_id_t                 dbg_id,
   output logic [`CORE_GPR_W-1:0]       dbg_gpr,
   output logic [`CORE_MM_W-1:0]        dbg_mm
);

   logic                    ag_valid;
   addr_payload_t           ag_data;
   logic                    me_stall;
   logic                    me_valid;
   mem_payload_t            me_data;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_we;
   logic [`CORE_ADDR_W-1:0] wb_adr;
   wb_sel_t                 wb_sel;
   logic [`CORE_MM_W-1:0]   wb_dat_w;
   logic                    wb_ack;
   logic [`CORE_MM_W-1:0]   wb_dat_r;

   address_stage u_address_stage (
      .CLK(CLK), .reset(reset),
      .issue_valid(issue_valid), .issue_ready(issue_ready),
      .issue_kind(issue_kind), .issue_size(issue_size), .issue_drid(issue_drid),
      .issue_a(issue_a), .issue_b(issue_b), .issue_mm_a(issue_mm_a), .issue_sp(issue_sp),
      .issue_base(issue_base), .issue_disp(issue_disp), .issue_add_imm(issue_add_imm),
      .stall(me_stall), .out_valid(ag_valid), .out_data(ag_data)
   );

   memory_stage u_memory_stage (
      .CLK(CLK), .reset(reset),
      .in_valid(ag_valid), .in_data(ag_data), .stall(me_stall),
      .out_valid(me_valid), .out_data(me_data),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
   );

   writeback_stage u_writeback_stage (
      .CLK(CLK), .reset(reset),
      .in_valid(me_valid), .in_data(me_data),
      .retire_valid(retire_valid), .retire_kind(retire_kind), .retire_drid(retire_drid),
      .retire_gpr(retire_gpr), .retire_mm(retire_mm), .retire_sp(retire_sp),
      .dbg_id(dbg_id), .dbg_gpr(dbg_gpr), .dbg_mm(dbg_mm)
   );

   data_ram u_data_ram (
      .CLK(CLK), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .wb_dat_r(wb_dat_r)
   );

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module memory_stage
   import uop_pkg::*;
   import wb_pkg::*;
(
   input  wire logic                    CLK,
   input  wire logic                    reset,
   input  wire logic                    in_valid,
   input  wire addr_payload_t           in_data,
   output logic                         stall,
   output logic                         out_valid,
   output mem_payload_t                 out_data,
   output logic                         wb_cyc,
   output logic                         wb_stb,
   output logic                         wb_we,
   output logic [`CORE_ADDR_W-1:0]      wb_adr,
   output wb_sel_t                      wb_sel,
   output logic [`CORE_MM_W-1:0]        wb_dat_w,
   input  wire logic                    wb_ack,
   input  wire logic [`CORE_MM_W-1:0]   wb_dat_r
);

   logic                  is_load;
   logic                  is_store;
   logic                  is_mem;
   logic [5:0]            shift;
   logic [`CORE_MM_W-1:0] rd_shifted;
   mem_payload_t          result;

   assign is_load  = (in_data.kind == op_load_gpr) || (in_data.kind == op_load_mm);
   assign is_store = (in_data.kind == op_store);
   assign is_mem   = is_load || is_store;
   assign shift    = {in_data.addr[2:0], 3'b000};

   // The bus cycle runs for as long as the address latch presents a memory micro-op.
   assign wb_cyc = in_valid && is_mem;
   assign wb_stb = wb_cyc;
   assign wb_we  = in_valid && is_store;
   assign wb_adr = in_data.addr;
   assign wb_sel = size_to_sel(in_data.size, in_data.addr[2:0]);

   // A qword store carries the full MM operand.
   assign wb_dat_w = (in_data.size == size_qword) ? in_data.mm_a
                                                   : ({32'b0, in_data.a} << shift);

   assign rd_shifted = wb_dat_r >> shift;

   always_comb begin
      result.kind     = in_data.kind;
      result.size     = in_data.size;
      result.drid     = in_data.drid;
      result.a_out    = is_load ? (rd_shifted[`CORE_GPR_W-1:0] & size_to_mask(in_data.size))
                                : in_data.a;
      result.mm_a_out = is_load ? wb_dat_r : in_data.mm_a;
      result.b_out    = (in_data.kind == op_move) ? in_data.a : in_data.b;
      result.sp_out   = in_data.sp + (in_data.add_imm ? in_data.b : '0);
   end

   assign stall = in_valid && is_mem && !wb_ack;

   stage_latch #(
      .payload_t(mem_payload_t)
   ) u_latch (
      .CLK      (CLK),
      .reset    (reset),
      .in_valid (in_valid && (!is_mem || wb_ack)),
      .in_data  (result),
      .stall    (1'b0),           // Writeback always accepts.
      .out_valid(out_valid),
      .out_data (out_data),
      .ready    ()
   );

   // The address latch must hold the request until the slave answers.
   a_adr_held: assert property (@(posedge CLK) disable iff (reset)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)));

endmodule

`default_nettype wire

//--- logic/stage_latch.sv
`timescale 1ns/10ps
`default_nettype none

module stage_latch #(
   parameter type payload_t = logic
) (
   input  wire logic CLK,
   input  wire logic reset,
   input  wire logic in_valid,
   input  wire payload_t in_data,
   input  wire logic stall,
   output logic      out_valid,
   output payload_t  out_data,
   output logic      ready
);

   logic load;

   assign load  = !out_valid || !stall; // Empty, or the item moves on this cycle.
   assign ready = load;

   always_ff @(posedge CLK) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (load && in_valid) begin
         out_data <= in_data;
      end
   end

endmodule

`default_nettype wire

//--- logic/uop_pkg.sv
`default_nettype none
`include "core_settings.svh"

package uop_pkg;

   typedef enum logic [2:0] {
      op_load_gpr = 3'd0,
      op_load_mm  = 3'd1,
      op_store    = 3'd2,
      op_move     = 3'd3,
      op_sp_add   = 3'd4,
      op_nop      = 3'd5
   } uop_kind_t;

   typedef enum logic [1:0] {
      size_byte  = 2'd0,
      size_word  = 2'd1,
      size_dword = 2'd2,
      size_qword = 2'd3
   } op_size_t;

   typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_id_t;

   // Leaves the address stage.
   typedef struct packed {
      uop_kind_t               kind;
      op_size_t                size;
      reg_id_t                 drid;
      logic [`CORE_GPR_W-1:0]  a;
      logic [`CORE_GPR_W-1:0]  b;
      logic [`CORE_MM_W-1:0]   mm_a;
      logic [`CORE_GPR_W-1:0]  sp;
      logic [`CORE_ADDR_W-1:0] addr;
      logic                    add_imm; // Add B to the stack value.
   } addr_payload_t;

   // Leaves the memory stage.
   typedef struct packed {
      uop_kind_t              kind;
      op_size_t               size;
      reg_id_t                drid;
      logic [`CORE_GPR_W-1:0] a_out;
      logic [`CORE_GPR_W-1:0] b_out;
      logic [`CORE_MM_W-1:0]  mm_a_out;
      logic [`CORE_GPR_W-1:0] sp_out;
   } mem_payload_t;

   // Low-byte mask of a general register for an operand size.
   function automatic logic [`CORE_GPR_W-1:0] size_to_mask(op_size_t size);
      logic [`CORE_GPR_W-1:0] mask;
      case (size)
         size_byte: mask = 32'h0000_00ff;
         size_word: mask = 32'h0000_ffff;
         default:   mask = 32'hffff_ffff;
      endcase
      return mask;
   endfunction

endpackage

`default_nettype wire

//--- logic/wb_pkg.sv
`default_nettype none
`include "core_settings.svh"

package wb_pkg;

   import uop_pkg::*;

   typedef logic [`CORE_MM_W/8-1:0] wb_sel_t;

   // Byte lanes touched by an access of the given size at the given offset in the word.
   function automatic wb_sel_t size_to_sel(op_size_t size, logic [2:0] lo);
      wb_sel_t sel;
      case (size)
         size_byte:  sel = wb_sel_t'(8'h01) << lo;
         size_word:  sel = wb_sel_t'(8'h03) << lo;
         size_dword: sel = wb_sel_t'(8'h0f) << lo;
         default:    sel = wb_sel_t'(8'hff);
      endcase
      return sel;
   endfunction

endpackage

`default_nettype wire

//--- logic/writeback_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module writeback_stage
   import uop_pkg::*;
(
   input  wire logic               CLK,
   input  wire logic               reset,
   input  wire logic               in_valid,
   input  wire mem_payload_t       in_data,
   output logic                    retire_valid,
   output uop_kind_t               retire_kind,
   output reg_id_t                 retire_drid,
   output logic [`CORE_GPR_W-1:0]  retire_gpr,
   output logic [`CORE_MM_W-1:0]   retire_mm,
   output logic [`CORE_GPR_W-1:0]  retire_sp,
   input  wire reg_id_t            dbg_id,
   output logic [`CORE_GPR_W-1:0]  dbg_gpr,
   output logic [`CORE_MM_W-1:0]   dbg_mm
);

   logic [`CORE_GPR_W-1:0] gpr [`CORE_NUM_REGS];
   logic [`CORE_MM_W-1:0]  mm  [`CORE_NUM_REGS];
   logic                   gpr_we;
   logic                   mm_we;
   logic [`CORE_GPR_W-1:0] gpr_src;
   logic [`CORE_GPR_W-1:0] gpr_mask;
   logic [`CORE_GPR_W-1:0] gpr_merged;

   assign gpr_we   = in_valid && ((in_data.kind == op_load_gpr) || (in_data.kind == op_move));
   assign mm_we    = in_valid && (in_data.kind == op_load_mm);
   assign gpr_src  = (in_data.kind == op_move) ? in_data.b_out : in_data.a_out;
   assign gpr_mask = size_to_mask(in_data.size);

   // Narrow writes keep the upper bytes of the old register value.
   assign gpr_merged = (gpr[in_data.drid] & ~gpr_mask) | (gpr_src & gpr_mask);

   always_ff @(posedge CLK) begin
      if (reset) begin
         for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            gpr[i] <= '0;
            mm[i]  <= '0;
         end
      end else begin
         if (gpr_we) gpr[in_data.drid] <= gpr_merged;
         if (mm_we)  mm[in_data.drid]  <= in_data.mm_a_out;
      end
   end

   always_ff @(posedge CLK) begin
      if (reset) begin
         retire_valid <= 1'b0;
      end else begin
         retire_valid <= in_valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (in_valid) begin
         retire_kind <= in_data.kind;
         retire_drid <= in_data.drid;
         retire_gpr  <= gpr_we ? gpr_merged : in_data.a_out; // Stores report the data only.
         retire_mm   <= in_data.mm_a_out;
         retire_sp   <= in_data.sp_out;
      end
   end

   assign dbg_gpr = gpr[dbg_id];
   assign dbg_mm  = mm[dbg_id];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mem_pipe_tb \
   -f list.f -o sim_mem_pipe

out=$(./obj_dir/sim_mem_pipe)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
   exit 0
fi
exit 1
